//--- verilog/busPkg.sv
`default_nettype none

package busPkg;

    typedef logic [31:0] wordT;   // Data word
    typedef logic [31:0] addrT;   // Byte address, word aligned on this bus

    // Master to slave, held by the master until ack
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        addrT adr;
        wordT dat;   // Write data
    } wbReqT;

    // Slave to master
    typedef struct packed {
        logic ack;
        wordT dat;   // Read data, valid with ack
    } wbRspT;

endpackage

`default_nettype wire

//--- verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    import busPkg::*;

    typedef logic [4:0] regIdxT;   // Register index x0..x31

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011   // ecall only
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpT;

    // One entry per retired instruction
    typedef struct packed {
        logic valid;
        addrT pc;
        wordT instr;
    } retireT;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import busPkg::*;
    import rvIsaPkg::*;
(
    input  logic   CLK,
    input  logic   rstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  logic   wrEn,
    input  wordT   wrData,
    output wordT   rd1,
    output wordT   rd2
);

    wordT regs [32];

    // x0 is never written, so it reads as zero after reset
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != '0)) begin
            regs[rd] <= wrData;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import busPkg::*;
    import rvIsaPkg::*;
(
    input  logic       opIsReg,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  wordT       a,
    input  wordT       b,
    output wordT       result,
    output logic       zero
);

    aluOpT op;

    always_comb begin
        case (funct3)
            3'b000:  op = (opIsReg && funct7b5) ? ALU_SUB : ALU_ADD;   // addi never subtracts
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);   // Equality test for beq

endmodule

`default_nettype wire

//--- verilog/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore
    import busPkg::*;
    import rvIsaPkg::*;
#(
    parameter addrT ResetPc = '0
) (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   run,
    output wbReqT  busReq,
    input  wbRspT  busRsp,
    output retireT retire,
    output logic   halted
);

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, HALT} stateT;

    stateT  state;
    addrT   pc;        // PC of the instruction in flight
    wordT   ir;
    opcodeT opcode;
    regIdxT rs1, rs2, rd;
    logic [2:0] funct3;
    wordT   immI, immS, immB;
    wordT   rd1, rd2;
    wordT   aluB, aluResult;
    logic   aluZero;
    logic   isLoad, isStore, isBranch, isAluOp;
    logic   wrEn;
    wordT   wrData;

    // Field decode
    assign opcode = opcodeT'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    assign immI = {{20{ir[31]}}, ir[31:20]};
    assign immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

    assign isLoad   = (opcode == LOAD);
    assign isStore  = (opcode == STORE);
    assign isBranch = (opcode == BRANCH);
    assign isAluOp  = (opcode == OP) || (opcode == OPIMM);

    // Register operand for OP and beq, else an immediate
    assign aluB = (opcode == OP || isBranch) ? rd2 : (isStore ? immS : immI);

    regFile uRegFile (
        .CLK    (CLK),
        .rstN   (rstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wrEn   (wrEn),
        .wrData (wrData),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    // Loads and stores force an add, beq forces a subtract
    aluUnit uAlu (
        .opIsReg  ((opcode == OP) || isBranch),
        .funct3   ((isLoad || isStore) ? 3'b000 : funct3),
        .funct7b5 (ir[30] || isBranch),
        .a        (rd1),
        .b        (aluB),
        .result   (aluResult),
        .zero     (aluZero)
    );

    // Load data lands in the ack cycle of the memory step
    assign wrEn   = (state == EXEC && isAluOp) || (state == MEM && isLoad && busRsp.ack);
    assign wrData = (state == MEM) ? busRsp.dat : aluResult;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            pc    <= ResetPc;
        end else begin
            case (state)
                IDLE: if (run) state <= FETCH;
                FETCH: if (busRsp.ack) state <= EXEC;
                EXEC: begin
                    if (isLoad || isStore) begin
                        state <= MEM;               // PC moves on after the access
                    end else if (opcode == SYSTEM) begin
                        state <= HALT;
                    end else begin
                        state <= FETCH;
                        if (isBranch && funct3 == 3'b000 && aluZero) pc <= pc + immB;
                        else pc <= pc + 32'd4;
                    end
                end
                MEM: begin
                    if (busRsp.ack) begin
                        state <= FETCH;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= HALT;             // Stays until reset
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == FETCH && busRsp.ack) ir <= busRsp.dat;
    end

    // Bus master, request held until ack
    assign busReq.cyc = (state == FETCH) || (state == MEM);
    assign busReq.stb = busReq.cyc;
    assign busReq.we  = (state == MEM) && isStore;
    assign busReq.adr = (state == MEM) ? aluResult : pc;
    assign busReq.dat = rd2;

    assign retire.valid = (state == EXEC && !isLoad && !isStore)
                        || (state == MEM && busRsp.ack);
    assign retire.pc    = pc;
    assign retire.instr = ir;

    assign halted = (state == HALT);

endmodule

`default_nettype wire

//--- verilog/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter
    import busPkg::*;
(
    input  logic  CLK,
    input  logic  rstN,
    input  wbReqT hostReq,
    input  wbReqT coreReq,
    output wbRspT hostRsp,
    output wbRspT coreRsp,
    output wbReqT memReq,
    input  wbRspT memRsp
);

    typedef enum logic [1:0] {NONE, HOST, CORE} ownerT;

    ownerT owner;
    logic  grantHost, grantCore;

    // Idle bus grants straight from live requests, host first
    assign grantHost = (owner == HOST) || (owner == NONE && hostReq.cyc);
    assign grantCore = (owner == CORE) || (owner == NONE && !hostReq.cyc && coreReq.cyc);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            owner <= NONE;
        end else begin
            case (owner)
                NONE: begin
                    if (hostReq.cyc) owner <= HOST;
                    else if (coreReq.cyc) owner <= CORE;
                end
                HOST: if (!hostReq.cyc) owner <= NONE;
                CORE: if (!coreReq.cyc) owner <= NONE;
                default: owner <= NONE;
            endcase
        end
    end

    assign memReq = grantHost ? hostReq : (grantCore ? coreReq : '0);

    // Only the owner sees ack
    assign hostRsp = '{ack: memRsp.ack && grantHost, dat: memRsp.dat};
    assign coreRsp = '{ack: memRsp.ack && grantCore, dat: memRsp.dat};

endmodule

`default_nettype wire

//--- verilog/unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory
    import busPkg::*;
#(
    parameter int MemWords = 256
) (
    input  logic  CLK,
    input  logic  rstN,
    input  wbReqT req,
    output wbRspT rsp
);

    localparam int IdxW = $clog2(MemWords);

    wordT            mem [MemWords];
    wordT            rdData;
    logic            ackReg;
    logic [IdxW-1:0] wordIdx;
    logic            access;

    assign wordIdx = req.adr[IdxW+1:2];   // Byte address to word index
    assign access  = req.cyc && req.stb;

    // One ack per request, never two in a row
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) ackReg <= 1'b0;
        else       ackReg <= access && !ackReg;
    end

    always_ff @(posedge CLK) begin
        if (access && !ackReg) rdData <= mem[wordIdx];
        if (access && ackReg && req.we) mem[wordIdx] <= req.dat;   // Write in ack cycle
    end

    assign rsp.ack = ackReg;
    assign rsp.dat = rdData;

endmodule

`default_nettype wire

//--- verilog/singleCpu.sv
`timescale 1ns/1ps
`default_nettype none

module singleCpu
    import busPkg::*;
    import rvIsaPkg::*;
#(
    parameter int   MemWords = 256,
    parameter addrT ResetPc  = '0
) (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   run,
    input  wbReqT  hostReq,
    output wbRspT  hostRsp,
    output retireT retire,
    output logic   halted
);

    wbReqT coreReq, memReq;
    wbRspT coreRsp, memRsp;

    cpuCore #(
        .ResetPc (ResetPc)
    ) uCore (
        .CLK    (CLK),
        .rstN   (rstN),
        .run    (run),
        .busReq (coreReq),
        .busRsp (coreRsp),
        .retire (retire),
        .halted (halted)
    );

    // Host and core share the one memory
    busArbiter uArbiter (
        .CLK     (CLK),
        .rstN    (rstN),
        .hostReq (hostReq),
        .coreReq (coreReq),
        .hostRsp (hostRsp),
        .coreRsp (coreRsp),
        .memReq  (memReq),
        .memRsp  (memRsp)
    );

    unifiedMemory #(
        .MemWords (MemWords)
    ) uMemory (
        .CLK  (CLK),
        .rstN (rstN),
        .req  (memReq),
        .rsp  (memRsp)
    );

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod = 50   // 100 ns clock
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #HalfPeriod CLK = ~CLK;
    end

endmodule

`default_nettype wire

//--- verification/resultChecker.sv
`timescale 1ns/1ps
`default_nettype none

module resultChecker
    import busPkg::*;
    import rvIsaPkg::*;
#(
    parameter int MemWords = 256
) (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   run,
    input  wbReqT  hostReq,
    input  wbRspT  hostRsp,
    input  retireT retire,
    input  logic   halted,
    output int     checks,
    output int     errors
);

    localparam int IdxW = $clog2(MemWords);

    wordT model [MemWords];   // Filled from observed host writes
    wordT x [32];
    addrT modelPc;
    logic modelHalted;

    task automatic compare(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic wordT sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // One instruction of the reference model
    task automatic stepModel(input wordT ins);
        logic [4:0] rdI, r1, r2;
        wordT a, b, res, ea;
        addrT nextPc;
        logic wr;
        rdI = ins[11:7];
        r1 = ins[19:15];
        r2 = ins[24:20];
        a = x[r1];
        b = x[r2];
        nextPc = modelPc + 32'd4;
        wr = 1'b0;
        res = '0;
        case (ins[6:0])
            7'b0110011: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'd0:    res = ins[30] ? a - b : a + b;
                    3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd4:    res = a ^ b;
                    3'd6:    res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0010011: begin
                wr = 1'b1;
                res = a + sext12(ins[31:20]);
            end
            7'b0000011: begin
                wr = 1'b1;
                ea = a + sext12(ins[31:20]);
                res = model[ea[IdxW+1:2]];
            end
            7'b0100011: begin
                ea = a + sext12({ins[31:25], ins[11:7]});
                model[ea[IdxW+1:2]] = b;
            end
            7'b1100011: begin
                if (a == b) begin
                    nextPc = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1110011: modelHalted = 1'b1;   // ecall
            default: ;
        endcase
        if (wr && rdI != '0) x[rdI] = res;
        modelPc = nextPc;
    endtask

    always @(negedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                x[i] = '0;
            end
            modelPc = '0;
            modelHalted = 1'b0;
            checks = 0;
            errors = 0;
        end else begin
            if (!run) begin
                checks++;
                if (halted || retire.valid) complain("Core was active before run was raised");
            end
            if (hostRsp.ack && !hostReq.cyc) complain("Host port saw an ack with no request");
            if (hostReq.cyc && hostRsp.ack) begin
                if (hostReq.we) model[hostReq.adr[IdxW+1:2]] = hostReq.dat;
                else compare("hostRsp.dat", hostRsp.dat, model[hostReq.adr[IdxW+1:2]]);
            end
            // Halted must follow the ecall retire and stay high
            if (modelHalted) begin
                checks++;
                if (!halted) complain("Halted is low after the ecall retired");
            end
            if (retire.valid) begin
                if (modelHalted) begin
                    complain("An instruction retired after the ecall");
                end else begin
                    compare("retire.pc", retire.pc, modelPc);
                    compare("retire.instr", retire.instr, model[modelPc[IdxW+1:2]]);
                    stepModel(model[modelPc[IdxW+1:2]]);
                end
            end
            if (halted && !modelHalted) complain("Core halted before the ecall retired");
        end
    end

endmodule

`default_nettype wire

//--- verification/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTop
    import busPkg::*;
    import rvIsaPkg::*;
();

    localparam int MemWords  = 256;
    localparam int ProgLen   = 40;    // Random instructions ahead of the ecall
    localparam int DataBase  = 128;   // First word of the data region
    localparam int DataWords = 64;
    localparam int WaitLimit = 100;
    localparam int RunLimit  = 4000;

    logic   CLK, rstN, run, halted;
    wbReqT  hostReq;
    wbRspT  hostRsp;
    retireT retire;
    int     checks, errors, lastChecks, lastErrors;
    logic   timedOut;
    wordT   prog [ProgLen + 1];

    clockGen uClock (.CLK(CLK));

    singleCpu #(
        .MemWords (MemWords)
    ) dut (
        .CLK     (CLK),
        .rstN    (rstN),
        .run     (run),
        .hostReq (hostReq),
        .hostRsp (hostRsp),
        .retire  (retire),
        .halted  (halted)
    );

    resultChecker #(
        .MemWords (MemWords)
    ) uChecker (
        .CLK     (CLK),
        .rstN    (rstN),
        .run     (run),
        .hostReq (hostReq),
        .hostRsp (hostRsp),
        .retire  (retire),
        .halted  (halted),
        .checks  (checks),
        .errors  (errors)
    );

    // Registers x0..x7 only, so results feed later instructions
    function automatic wordT randomInstr(input int idx);
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [12:0] off;
        rd  = 5'($urandom_range(7));
        rs1 = 5'($urandom_range(7));
        rs2 = 5'($urandom_range(7));
        imm = 12'(4 * (DataBase + $urandom_range(DataWords - 1)));
        off = 13'(4 * (1 + $urandom_range(ProgLen - idx - 1)));   // Forward and never past ecall
        case ($urandom_range(7))
            0, 1, 2: begin
                case ($urandom_range(5))
                    0:       return {7'h00, rs2, rs1, 3'd0, rd, 7'b0110011};   // add
                    1:       return {7'h20, rs2, rs1, 3'd0, rd, 7'b0110011};   // sub
                    2:       return {7'h00, rs2, rs1, 3'd7, rd, 7'b0110011};
                    3:       return {7'h00, rs2, rs1, 3'd6, rd, 7'b0110011};
                    4:       return {7'h00, rs2, rs1, 3'd4, rd, 7'b0110011};
                    default: return {7'h00, rs2, rs1, 3'd2, rd, 7'b0110011};   // slt
                endcase
            end
            3, 4:    return {12'($urandom_range(4095)), rs1, 3'd0, rd, 7'b0010011};
            5:       return {imm, 5'd0, 3'd2, rd, 7'b0000011};
            6:       return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'b0100011};
            default: return {off[12], off[10:5], rs2, rs1, 3'd0, off[4:1], off[11], 7'b1100011};
        endcase
    endfunction

    // One Wishbone classic cycle on the host port and an idle cycle after it
    task automatic hostAccess(input logic we, input addrT adr, input wordT dat);
        int n;
        if (!timedOut) begin
            hostReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
            n = 0;
            @(negedge CLK);
            while (!hostRsp.ack && n < WaitLimit) begin
                @(negedge CLK);
                n++;
            end
            if (!hostRsp.ack) begin
                timedOut = 1'b1;
                $display("Host access to %h got no ack within %0d cycles", adr, WaitLimit);
            end
            @(posedge CLK);
            #1;
            hostReq = '0;
            @(posedge CLK);
            #1;
        end
    endtask

    // Random code reads compete with the core until it halts
    task automatic runProgram();
        int n;
        n = 0;
        while (!halted && !timedOut && n < RunLimit) begin
            if ($urandom_range(3) == 0) begin
                hostAccess(1'b0, addrT'(4 * $urandom_range(ProgLen)), '0);
            end else begin
                @(posedge CLK);
                #1;
            end
            n++;
        end
        if (!halted && !timedOut) begin
            timedOut = 1'b1;
            $display("Core did not halt within %0d steps", RunLimit);
        end
    endtask

    task automatic endTest(input string name);
        $display("Test %s: %0d checks, %0d errors", name, checks - lastChecks,
                 errors - lastErrors);
        lastChecks = checks;
        lastErrors = errors;
    endtask

    initial begin
        void'($urandom(13));
        rstN = 1'b0;
        run = 1'b0;
        hostReq = '0;
        timedOut = 1'b0;
        lastChecks = 0;
        lastErrors = 0;
        for (int i = 0; i < ProgLen; i++) begin
            prog[i] = randomInstr(i);
        end
        prog[ProgLen] = 32'h0000_0073;   // ecall
        repeat (10) @(posedge CLK);
        #1;
        rstN = 1'b1;
        repeat (5) @(posedge CLK);       // Idle with run low
        #1;
        endTest("reset");

        for (int i = 0; i <= ProgLen; i++) begin
            hostAccess(1'b1, addrT'(4 * i), prog[i]);
        end
        for (int i = 0; i < DataWords; i++) begin
            hostAccess(1'b1, addrT'(4 * (DataBase + i)), $urandom());
        end
        for (int i = 0; i <= ProgLen; i++) begin
            hostAccess(1'b0, addrT'(4 * i), '0);
        end
        for (int i = 0; i < DataWords; i++) begin
            hostAccess(1'b0, addrT'(4 * (DataBase + i)), '0);
        end
        endTest("host load and readback");

        run = 1'b1;
        runProgram();
        endTest("retire trace with host traffic");

        repeat (50) @(posedge CLK);      // No retire may follow the ecall
        #1;
        endTest("halt");

        for (int i = 0; i < DataWords; i++) begin
            hostAccess(1'b0, addrT'(4 * (DataBase + i)), '0);
        end
        endTest("final memory");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (timedOut || errors != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/busPkg.sv
verilog/rvIsaPkg.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/cpuCore.sv
verilog/busArbiter.sv
verilog/unifiedMemory.sv
verilog/singleCpu.sv
verification/clockGen.sv
verification/resultChecker.sv
verification/tbTop.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tbTop -f tb.f -o simTop
out=$(./obj_dir/simTop)
echo "$out"
echo "$out" | grep -q "No errors"
